//--- hw/otp_part_pkg.sv
package otp_part_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Digest block, one scrambling block
  parameter int BlockWidth    = 64;
  // One macro word, macro addresses count halfwords
  parameter int OtpWidth      = 16;
  // Byte and halfword address widths of the OTP space
  parameter int ByteAddrWidth = 11;
  parameter int OtpAddrWidth  = 10;
  // Size field holds number of macro words minus one
  parameter int OtpSizeWidth  = 2;
  // Bus port carries a 32-bit word address
  parameter int SwAddrWidth   = 9;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Error codes, shared with the macro response
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    AccessError         = 3'h4,
    CheckFailError      = 3'h5,
    FsmStateError       = 3'h6
  } otp_err_e;

  // Partition FSM states, code 7 is unused and invalid
  typedef enum logic [2:0] {
    ResetSt    = 3'h0,
    InitSt     = 3'h1,
    InitWaitSt = 3'h2,
    IdleSt     = 3'h3,
    ReadSt     = 3'h4,
    ReadWaitSt = 3'h5,
    ErrorSt    = 3'h6
  } part_state_e;

  // Macro address source
  typedef enum logic {
    DigestSel = 1'b0,
    DataSel   = 1'b1
  } addr_sel_e;

endpackage

//--- hw/otp_part_addr_dec.sv
`timescale 1ns/1ps

module otp_part_addr_dec #(
  // Byte offset of the partition, 64-bit aligned
  parameter int unsigned PartOffset = 64,
  // Partition size in bytes, digest in the last block
  parameter int unsigned PartSize   = 64
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Bus side
  input  logic [otp_part_pkg::SwAddrWidth-1:0]  tlul_addr_i,
  input  logic                                  tlul_gnt_i,
  // Address source from the FSM
  input  otp_part_pkg::addr_sel_e               addr_sel_i,
  output logic                                  addr_in_range_o,
  // Macro side
  output logic [otp_part_pkg::OtpAddrWidth-1:0] otp_addr_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0] otp_size_o
);

  import otp_part_pkg::*;

  ////////////////////////////////////////
  // Partition bounds
  ////////////////////////////////////////

  // One extra bit so the end of the top partition is representable
  localparam logic [ByteAddrWidth:0] PartEnd =
      (ByteAddrWidth+1)'(PartOffset + PartSize);
  localparam logic [ByteAddrWidth-1:0] PartStart = ByteAddrWidth'(PartOffset);
  // Digest lives in the last 64-bit block
  localparam logic [ByteAddrWidth-1:0] DigestOffset =
      ByteAddrWidth'(PartOffset + PartSize - BlockWidth / 8);
  // Halfword address drops the low byte bits
  localparam int AddrShift = ByteAddrWidth - OtpAddrWidth;

  logic [SwAddrWidth-1:0]   tlul_addr_q;
  logic [ByteAddrWidth-1:0] byte_addr;
  logic [ByteAddrWidth-1:0] addr_calc;

  // Word address captured on each grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tlul_addr_q <= '0;
    end else if (tlul_gnt_i) begin
      tlul_addr_q <= tlul_addr_i;
    end
  end

  // Word to byte address
  assign byte_addr = {tlul_addr_q, 2'b00};

  // Range check against the latched address
  assign addr_in_range_o = (byte_addr >= PartStart) && ({1'b0, byte_addr} < PartEnd);

  ////////////////////////////////////////
  // Macro address and size
  ////////////////////////////////////////

  assign addr_calc  = (addr_sel_i == DigestSel) ? DigestOffset : byte_addr;
  assign otp_addr_o = addr_calc[ByteAddrWidth-1:AddrShift];

  // Full block for the digest, one 32-bit word for data
  assign otp_size_o = (addr_sel_i == DigestSel) ?
                      OtpSizeWidth'(BlockWidth / OtpWidth - 1) :
                      OtpSizeWidth'(32 / OtpWidth - 1);

endmodule

//--- hw/otp_part_fsm.sv
`timescale 1ns/1ps

module otp_part_fsm #(
  // Init reads the digest block when set
  parameter bit SwDigest = 1'b1
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Init handshake
  input  logic                   init_req_i,
  output logic                   init_done_o,
  // Escalation forces the terminal state
  input  logic                   escalate_en_i,
  output otp_part_pkg::otp_err_e error_o,
  output logic                   fsm_err_o,
  // Bus side
  input  logic                   tlul_req_i,
  output logic                   tlul_gnt_o,
  output logic                   tlul_rvalid_o,
  output logic [1:0]             tlul_rerror_o,
  // Checks from decoder and lock logic
  input  logic                   addr_in_range_i,
  input  logic                   read_lock_i,
  // Macro side
  output logic                   otp_req_o,
  input  logic                   otp_gnt_i,
  input  logic                   otp_rvalid_i,
  input  otp_part_pkg::otp_err_e otp_err_i,
  // Datapath controls
  output otp_part_pkg::addr_sel_e addr_sel_o,
  output logic                   digest_en_o
);

  import otp_part_pkg::*;

  part_state_e state_d, state_q;
  otp_err_e    error_d, error_q;
  // Bus error owed for a grant taken in ErrorSt
  logic        pend_err_d, pend_err_q;

  assign error_o = error_q;

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    error_d       = error_q;
    pend_err_d    = 1'b0;
    init_done_o   = 1'b0;
    otp_req_o     = 1'b0;
    addr_sel_o    = DigestSel;
    digest_en_o   = 1'b0;
    tlul_gnt_o    = 1'b0;
    tlul_rvalid_o = 1'b0;
    tlul_rerror_o = 2'b00;
    fsm_err_o     = 1'b0;

    case (state_q)
      // Wait for the init pulse
      ResetSt: begin
        if (init_req_i) begin
          if (SwDigest) begin
            state_d = InitSt;
          end else begin
            state_d = IdleSt;
          end
        end
      end
      // Request the digest block, hold until granted
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = InitWaitSt;
        end
      end
      // Store digest, correctable errors are only noted
      InitWaitSt: begin
        if (otp_rvalid_i) begin
          digest_en_o = 1'b1;
          if (otp_err_i inside {NoError, MacroEccCorrError}) begin
            state_d = IdleSt;
            if (otp_err_i != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            state_d = ErrorSt;
            error_d = otp_err_i;
          end
        end
      end
      // Grant bus reads, soft errors clear here
      IdleSt: begin
        init_done_o = 1'b1;
        if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          error_d    = NoError;
          state_d    = ReadSt;
        end
      end
      // Range and lock check, then request the word
      ReadSt: begin
        init_done_o = 1'b1;
        if (addr_in_range_i && !read_lock_i) begin
          otp_req_o  = 1'b1;
          addr_sel_o = DataSel;
          if (otp_gnt_i) begin
            state_d = ReadWaitSt;
          end
        end else begin
          // Rejected access is not terminal
          state_d       = IdleSt;
          error_d       = AccessError;
          tlul_rvalid_o = 1'b1;
          tlul_rerror_o = 2'b11;
        end
      end
      // Macro response goes straight out on the bus
      ReadWaitSt: begin
        init_done_o = 1'b1;
        addr_sel_o  = DataSel;
        if (otp_rvalid_i) begin
          tlul_rvalid_o = 1'b1;
          if (otp_err_i inside {NoError, MacroEccCorrError}) begin
            state_d = IdleSt;
            if (otp_err_i != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            state_d       = ErrorSt;
            error_d       = otp_err_i;
            tlul_rerror_o = 2'b11;
          end
        end
      end
      // Terminal state, answer every grant with a bus error
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
        if (pend_err_q) begin
          tlul_rvalid_o = 1'b1;
          tlul_rerror_o = 2'b11;
        end else if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          pend_err_d = 1'b1;
        end
      end
      // Unused encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything
    if (escalate_en_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (state_q != ErrorSt) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ResetSt;
      error_q    <= NoError;
      pend_err_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      error_q    <= error_d;
      pend_err_q <= pend_err_d;
    end
  end

endmodule

//--- hw/otp_part_resp.sv
`timescale 1ns/1ps

module otp_part_resp #(
  // Nonzero digest locks writes
  parameter bit DigestWriteLock = 1'b1,
  // Nonzero digest locks reads
  parameter bit DigestReadLock  = 1'b0
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Digest capture
  input  logic                                digest_en_i,
  input  logic [otp_part_pkg::BlockWidth-1:0] otp_rdata_i,
  // Bus response status from the FSM
  input  logic                                tlul_rvalid_i,
  input  logic [1:0]                          tlul_rerror_i,
  // Lock sources
  input  logic                                init_done_i,
  input  logic                                read_lock_i,
  input  logic                                write_lock_i,
  output logic [otp_part_pkg::BlockWidth-1:0] digest_o,
  output logic [31:0]                         tlul_rdata_o,
  output logic                                read_lock_o,
  output logic                                write_lock_o
);

  logic digest_nz;
  logic read_lock_d;
  logic write_lock_d;

  // Digest register, cleared so locks see a defined value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_o <= '0;
    end else if (digest_en_i) begin
      digest_o <= otp_rdata_i;
    end
  end

  // Low word passes only on a clean response
  assign tlul_rdata_o = (tlul_rvalid_i && tlul_rerror_i == 2'b00) ? otp_rdata_i[31:0] : '0;

  ////////////////////////////////////////
  // Lock aggregation
  ////////////////////////////////////////

  assign digest_nz = (digest_o != '0);

  // Uninitialized partition is always locked
  assign write_lock_d = write_lock_i || !init_done_i || (DigestWriteLock && digest_nz);
  assign read_lock_d  = read_lock_i || !init_done_i || (DigestReadLock && digest_nz);

  // Locks come out of reset set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_lock_o <= 1'b1;
      read_lock_o  <= 1'b1;
    end else begin
      write_lock_o <= write_lock_d;
      read_lock_o  <= read_lock_d;
    end
  end

endmodule

//--- hw/otp_part_top.sv
`timescale 1ns/1ps

module otp_part_top #(
  parameter int unsigned PartOffset      = 64,
  parameter int unsigned PartSize        = 64,
  parameter bit          SwDigest        = 1'b1,
  parameter bit          DigestWriteLock = 1'b1,
  parameter bit          DigestReadLock  = 1'b0
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Init and status
  input  logic                                  init_req_i,
  output logic                                  init_done_o,
  input  logic                                  escalate_en_i,
  output otp_part_pkg::otp_err_e                error_o,
  output logic                                  fsm_err_o,
  // Locks
  input  logic                                  read_lock_i,
  input  logic                                  write_lock_i,
  output logic                                  read_lock_o,
  output logic                                  write_lock_o,
  output logic [otp_part_pkg::BlockWidth-1:0]   digest_o,
  // Bus port
  input  logic                                  tlul_req_i,
  output logic                                  tlul_gnt_o,
  input  logic [otp_part_pkg::SwAddrWidth-1:0]  tlul_addr_i,
  output logic [1:0]                            tlul_rerror_o,
  output logic                                  tlul_rvalid_o,
  output logic [31:0]                           tlul_rdata_o,
  // OTP macro port
  output logic                                  otp_req_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0] otp_size_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0] otp_addr_o,
  input  logic                                  otp_gnt_i,
  input  logic                                  otp_rvalid_i,
  input  logic [otp_part_pkg::BlockWidth-1:0]   otp_rdata_i,
  input  otp_part_pkg::otp_err_e                otp_err_i
);

  import otp_part_pkg::*;

  addr_sel_e addr_sel;
  logic      addr_in_range;
  logic      digest_en;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  otp_part_addr_dec #(
    .PartOffset (PartOffset),
    .PartSize   (PartSize)
  ) u_addr_dec (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .tlul_addr_i     (tlul_addr_i),
    .tlul_gnt_i      (tlul_gnt_o),
    .addr_sel_i      (addr_sel),
    .addr_in_range_o (addr_in_range),
    .otp_addr_o      (otp_addr_o),
    .otp_size_o      (otp_size_o)
  );

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////

  otp_part_fsm #(
    .SwDigest (SwDigest)
  ) u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .init_req_i      (init_req_i),
    .init_done_o     (init_done_o),
    .escalate_en_i   (escalate_en_i),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .tlul_req_i      (tlul_req_i),
    .tlul_gnt_o      (tlul_gnt_o),
    .tlul_rvalid_o   (tlul_rvalid_o),
    .tlul_rerror_o   (tlul_rerror_o),
    .addr_in_range_i (addr_in_range),
    // Registered read lock gates data reads
    .read_lock_i     (read_lock_o),
    .otp_req_o       (otp_req_o),
    .otp_gnt_i       (otp_gnt_i),
    .otp_rvalid_i    (otp_rvalid_i),
    .otp_err_i       (otp_err_i),
    .addr_sel_o      (addr_sel),
    .digest_en_o     (digest_en)
  );

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  otp_part_resp #(
    .DigestWriteLock (DigestWriteLock),
    .DigestReadLock  (DigestReadLock)
  ) u_resp (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .digest_en_i   (digest_en),
    .otp_rdata_i   (otp_rdata_i),
    .tlul_rvalid_i (tlul_rvalid_o),
    .tlul_rerror_i (tlul_rerror_o),
    .init_done_i   (init_done_o),
    .read_lock_i   (read_lock_i),
    .write_lock_i  (write_lock_i),
    .digest_o      (digest_o),
    .tlul_rdata_o  (tlul_rdata_o),
    .read_lock_o   (read_lock_o),
    .write_lock_o  (write_lock_o)
  );

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  // Clock period in ns
  parameter int PeriodNs    = 8,
  // Power-on reset length in clock cycles
  parameter int ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2);
      clk_o = ~clk_o;
    end
  end

  // Power-on reset, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tests/tb_otp_part.sv
`timescale 1ns/1ps

module tb_otp_part;

  import otp_part_pkg::*;

  ////////////////////////////////////////
  // Setup
  ////////////////////////////////////////

  // Partition parameters handed to the DUT
  localparam int PartOffset      = 64;
  localparam int PartSize        = 64;
  localparam bit DigestWriteLock = 1'b1;
  localparam bit DigestReadLock  = 1'b0;

  // OTP model constants
  localparam logic [9:0]  DigestHalfAddr = 10'((PartOffset + PartSize - 8) / 2);
  localparam logic [31:0] DataMask       = 32'h5a5a_0000;
  localparam logic [31:0] DataHigh       = 32'h0f0f_0f0f;
  // Cycles any wait may take
  localparam int          WaitLimit      = 64;

  logic        clk;
  logic        gen_rst_n;
  logic        tb_rst_n;
  logic        rst_n;
  // DUT inputs
  logic        init_req;
  logic        escalate_en;
  logic        read_lock;
  logic        write_lock;
  logic        tlul_req;
  logic [8:0]  tlul_addr;
  logic        otp_gnt;
  logic        otp_rvalid;
  logic [63:0] otp_rdata;
  otp_err_e    otp_err;
  // DUT outputs
  logic        init_done;
  otp_err_e    error;
  logic        fsm_err;
  logic        read_lock_out;
  logic        write_lock_out;
  logic [63:0] digest;
  logic        tlul_gnt;
  logic [1:0]  tlul_rerror;
  logic        tlul_rvalid;
  logic [31:0] tlul_rdata;
  logic        otp_req;
  logic [1:0]  otp_size;
  logic [9:0]  otp_addr;

  // Model state set per vector line
  logic [2:0]  cur_err;
  logic [63:0] cur_digest;
  // Request seen by the model at its last grant
  logic [9:0]  req_addr;
  logic [1:0]  req_size;
  int          mac_req_cnt = 0;
  int          rvalid_cnt  = 0;
  integer      seed        = 32'hd5f8_c814;
  int          gnt_delay;
  int          rsp_delay;

  // Expected state of the partition
  logic        fatal;
  logic        digest_nz;
  int          err_cnt;
  int          check_cnt;
  int          line_cnt;

  // Vector file fields
  int          fd;
  int          nchar;
  int          fields;
  string       line;
  logic [31:0] op;
  logic [31:0] vaddr;
  logic [31:0] vrl;
  logic [31:0] vwl;
  logic [31:0] vmerr;
  logic [63:0] vdigest;
  logic [31:0] vrerr;
  logic [31:0] verr;

  tb_clk_gen #(
    .PeriodNs    (8),
    .ResetCycles (2)
  ) u_clk_gen (
    .clk_o  (clk),
    .rst_no (gen_rst_n)
  );

  // Power-on reset or a reset from the vectors
  assign rst_n = gen_rst_n & tb_rst_n;

  otp_part_top #(
    .PartOffset      (PartOffset),
    .PartSize        (PartSize),
    .SwDigest        (1'b1),
    .DigestWriteLock (DigestWriteLock),
    .DigestReadLock  (DigestReadLock)
  ) DUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .init_req_i    (init_req),
    .init_done_o   (init_done),
    .escalate_en_i (escalate_en),
    .error_o       (error),
    .fsm_err_o     (fsm_err),
    .read_lock_i   (read_lock),
    .write_lock_i  (write_lock),
    .read_lock_o   (read_lock_out),
    .write_lock_o  (write_lock_out),
    .digest_o      (digest),
    .tlul_req_i    (tlul_req),
    .tlul_gnt_o    (tlul_gnt),
    .tlul_addr_i   (tlul_addr),
    .tlul_rerror_o (tlul_rerror),
    .tlul_rvalid_o (tlul_rvalid),
    .tlul_rdata_o  (tlul_rdata),
    .otp_req_o     (otp_req),
    .otp_size_o    (otp_size),
    .otp_addr_o    (otp_addr),
    .otp_gnt_i     (otp_gnt),
    .otp_rvalid_i  (otp_rvalid),
    .otp_rdata_i   (otp_rdata),
    .otp_err_i     (otp_err)
  );

  ////////////////////////////////////////
  // OTP macro model
  ////////////////////////////////////////

  // Digest block at the digest address and an address pattern elsewhere
  function automatic logic [63:0] model_data(input logic [9:0] half);
    if (half == DigestHalfAddr) begin
      model_data = cur_digest;
    end else begin
      model_data = {DataHigh, {22'd0, half} ^ DataMask};
    end
  endfunction

  // Grant after 0 to 3 cycles and answer 1 to 4 cycles later
  initial begin
    otp_gnt    = 1'b0;
    otp_rvalid = 1'b0;
    otp_rdata  = '0;
    otp_err    = NoError;
    forever begin
      @(negedge clk);
      otp_rvalid = 1'b0;
      if (rst_n && otp_req) begin
        gnt_delay = $unsigned($random(seed)) % 4;
        repeat (gnt_delay) @(negedge clk);
        req_addr = otp_addr;
        req_size = otp_size;
        otp_gnt  = 1'b1;
        @(negedge clk);
        otp_gnt     = 1'b0;
        mac_req_cnt = mac_req_cnt + 1;
        rsp_delay   = $unsigned($random(seed)) % 4 + 1;
        repeat (rsp_delay - 1) @(negedge clk);
        otp_rvalid = 1'b1;
        otp_rdata  = model_data(req_addr);
        otp_err    = otp_err_e'(cur_err);
      end
    end
  end

  // Count bus responses to match them against grants
  always @(posedge clk) begin
    if (rst_n && tlul_rvalid) begin
      rvalid_cnt <= rvalid_cnt + 1;
    end
  end

  ////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("Run stopped at %0t: %s", $time, reason);
    $display("Checks failed");
    $finish;
  endtask

  // All waits sample just after the falling edge
  task automatic wait_grant();
    int cycles;
    cycles = 0;
    #1;
    while (!tlul_gnt) begin
      if (cycles >= WaitLimit) begin
        abort_run("bus request was never granted");
      end
      @(negedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic wait_rvalid();
    int cycles;
    cycles = 0;
    #1;
    while (!tlul_rvalid) begin
      if (cycles >= WaitLimit) begin
        abort_run("no bus response after a grant");
      end
      @(negedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic wait_init_done();
    int cycles;
    cycles = 0;
    #1;
    while (!init_done) begin
      if (cycles >= WaitLimit) begin
        abort_run("init never completed");
      end
      @(negedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic wait_power_on();
    int cycles;
    cycles = 0;
    while (!gen_rst_n) begin
      if (cycles >= WaitLimit) begin
        abort_run("power-on reset never released");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  ////////////////////////////////////////
  // Operations
  ////////////////////////////////////////

  task automatic run_reset(input logic rl, input logic wl);
    @(negedge clk);
    tb_rst_n    = 1'b0;
    init_req    = 1'b0;
    escalate_en = 1'b0;
    tlul_req    = 1'b0;
    read_lock   = rl;
    write_lock  = wl;
    repeat (2) @(negedge clk);
    tb_rst_n  = 1'b1;
    fatal     = 1'b0;
    digest_nz = 1'b0;
    @(negedge clk);
    // Uninitialized partition is fully locked
    check_value("init_done after reset", 64'(init_done), 64'd0);
    check_value("read_lock after reset", 64'(read_lock_out), 64'd1);
    check_value("write_lock after reset", 64'(write_lock_out), 64'd1);
    check_value("error after reset", 64'(error), 64'(NoError));
    check_value("otp_req after reset", 64'(otp_req), 64'd0);
    check_value("fsm_err after reset", 64'(fsm_err), 64'd0);
    check_value("digest after reset", digest, 64'd0);
  endtask

  task automatic run_init(input logic [63:0] dig, input logic [2:0] merr, input logic rl,
                          input logic wl, input logic [2:0] exp_err);
    @(negedge clk);
    read_lock  = rl;
    write_lock = wl;
    cur_err    = merr;
    cur_digest = dig;
    @(negedge clk);
    init_req = 1'b1;
    @(negedge clk);
    init_req = 1'b0;
    wait_init_done();
    check_value("digest", digest, dig);
    check_value("error after init", 64'(error), 64'(exp_err));
    // Digest block request
    check_value("digest request address", 64'(req_addr), 64'(DigestHalfAddr));
    check_value("digest request size", 64'(req_size), 64'd3);
    digest_nz = (dig != 64'd0);
    // Locks follow one cycle later
    @(negedge clk);
    check_value("write_lock after init", 64'(write_lock_out),
                64'(wl | (DigestWriteLock && digest_nz)));
    check_value("read_lock after init", 64'(read_lock_out),
                64'(rl | (DigestReadLock && digest_nz)));
  endtask

  task automatic run_read(input logic [8:0] waddr, input logic rl, input logic wl,
                          input logic [2:0] merr, input logic [1:0] exp_rerr,
                          input logic [2:0] exp_err);
    int          byte_addr;
    int          rv_before;
    int          mac_before;
    logic [9:0]  half;
    logic        in_range;
    logic        accessed;
    logic [63:0] exp_data;
    byte_addr = int'(waddr) * 4;
    half      = 10'(byte_addr / 2);
    in_range  = (byte_addr >= PartOffset) && (byte_addr < PartOffset + PartSize);
    // Macro is only touched by an allowed read outside the error state
    accessed  = in_range && !rl && !fatal;
    exp_data  = model_data(half);
    @(negedge clk);
    read_lock  = rl;
    write_lock = wl;
    cur_err    = merr;
    // One cycle for the registered read lock
    @(negedge clk);
    rv_before  = rvalid_cnt;
    mac_before = mac_req_cnt;
    tlul_addr  = waddr;
    tlul_req   = 1'b1;
    wait_grant();
    @(negedge clk);
    tlul_req = 1'b0;
    wait_rvalid();
    check_value("rerror", 64'(tlul_rerror), 64'(exp_rerr));
    check_value("rdata", 64'(tlul_rdata), (exp_rerr == 2'd0) ? 64'(exp_data[31:0]) : 64'd0);
    if (accessed) begin
      check_value("read request address", 64'(req_addr), 64'(half));
      check_value("read request size", 64'(req_size), 64'd1);
    end
    @(negedge clk);
    if (accessed && merr != NoError && merr != MacroEccCorrError) begin
      fatal = 1'b1;
    end
    check_value("error after read", 64'(error), 64'(exp_err));
    check_value("init_done after read", 64'(init_done), 64'(!fatal));
    @(negedge clk);
    check_value("read_lock after read", 64'(read_lock_out),
                64'(rl | fatal | (DigestReadLock && digest_nz)));
    check_value("write_lock after read", 64'(write_lock_out),
                64'(wl | fatal | (DigestWriteLock && digest_nz)));
    check_value("bus responses per grant", 64'(rvalid_cnt - rv_before), 64'd1);
    check_value("macro requests per read", 64'(mac_req_cnt - mac_before), 64'(accessed));
  endtask

  task automatic run_escalate(input logic [2:0] exp_err);
    @(negedge clk);
    escalate_en = 1'b1;
    #1;
    check_value("fsm_err during escalation", 64'(fsm_err), 64'd1);
    @(negedge clk);
    escalate_en = 1'b0;
    #1;
    check_value("fsm_err after escalation", 64'(fsm_err), 64'd0);
    check_value("error after escalation", 64'(error), 64'(exp_err));
    fatal = 1'b1;
    @(negedge clk);
    check_value("init_done after escalation", 64'(init_done), 64'd0);
    check_value("read_lock after escalation", 64'(read_lock_out), 64'd1);
    check_value("write_lock after escalation", 64'(write_lock_out), 64'd1);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    tb_rst_n    = 1'b1;
    init_req    = 1'b0;
    escalate_en = 1'b0;
    read_lock   = 1'b0;
    write_lock  = 1'b0;
    tlul_req    = 1'b0;
    tlul_addr   = '0;
    cur_err     = 3'd0;
    cur_digest  = '0;
    fatal       = 1'b0;
    digest_nz   = 1'b0;
    err_cnt     = 0;
    check_cnt   = 0;
    line_cnt    = 0;
    fd = $fopen("tests/otp_part_vectors.txt", "r");
    wait_power_on();
    if (fd == 0) begin
      err_cnt++;
      $display("Cannot open tests/otp_part_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        nchar = $fgets(line, fd);
        // Skip comment and blank lines
        if (nchar > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                           op, vaddr, vrl, vwl, vmerr, vdigest, vrerr, verr);
          if (fields == 8) begin
            line_cnt++;
            case (op)
              0: run_reset(vrl[0], vwl[0]);
              1: run_init(vdigest, vmerr[2:0], vrl[0], vwl[0], verr[2:0]);
              2: run_read(vaddr[8:0], vrl[0], vwl[0], vmerr[2:0], vrerr[1:0], verr[2:0]);
              3: run_escalate(verr[2:0]);
              default: begin
                err_cnt++;
                $display("Unknown operation %0h in the vector file", op);
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end
    if (line_cnt == 0) begin
      err_cnt++;
      $display("The vector file holds no operations");
    end
    $display("Vector lines: %0d, checks: %0d, errors: %0d", line_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tests/otp_part_vectors.txt
# Columns, all hex: op addr read_lock write_lock macro_err digest exp_rerror exp_error
# op 0 reset, 1 init, 2 read, 3 escalate; addr is the 32-bit word address of a read
0 000 0 0 0 0000000000000000 0 0
1 000 0 0 0 3c5a96e1f00d7b42 0 0
2 010 0 0 0 0000000000000000 0 0
2 01c 0 0 0 0000000000000000 0 0
2 01e 0 0 0 0000000000000000 0 0
2 008 0 0 0 0000000000000000 3 4
2 011 0 0 0 0000000000000000 0 0
2 020 0 0 0 0000000000000000 3 4
2 012 1 0 0 0000000000000000 3 4
2 013 0 1 0 0000000000000000 0 0
2 014 0 0 2 0000000000000000 0 2
2 015 0 0 0 0000000000000000 0 0
2 016 0 0 3 0000000000000000 3 3
2 017 0 0 0 0000000000000000 3 3
2 1ff 0 0 0 0000000000000000 3 3
0 000 0 0 0 0000000000000000 0 0
1 000 0 0 2 81c4e0f7a9126d35 0 2
2 018 0 0 0 0000000000000000 0 0
3 000 0 0 0 0000000000000000 0 6
2 019 0 0 0 0000000000000000 3 6
0 000 0 0 0 0000000000000000 0 0
1 000 0 0 0 0000000000000000 0 0
2 01f 0 0 0 0000000000000000 0 0
2 010 0 0 1 0000000000000000 3 1

//--- all.f
hw/otp_part_pkg.sv
hw/otp_part_addr_dec.sv
hw/otp_part_fsm.sv
hw/otp_part_resp.sv
hw/otp_part_top.sv
tests/tb_clk_gen.sv
tests/tb_otp_part.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f all.f --top-module tb_otp_part -o sim_otp_part \
  && ./obj_dir/sim_otp_part > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
